// ==== hw/lieat_idu_pkg.sv ====
`default_nettype none

package lieat_idu_pkg;

  // datapath and instruction width
  localparam int XLEN    = 32;
  // architectural register index width
  localparam int REG_IDX = 5;

  // major opcodes kept by this decoder
  localparam logic [6:0] OPC_LOAD    = 7'b0000011;
  localparam logic [6:0] OPC_STORE   = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH  = 7'b1100011;
  localparam logic [6:0] OPC_JALR    = 7'b1100111;
  localparam logic [6:0] OPC_MISCMEM = 7'b0001111;
  localparam logic [6:0] OPC_JAL     = 7'b1101111;
  localparam logic [6:0] OPC_OP_IMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP      = 7'b0110011;
  localparam logic [6:0] OPC_AUIPC   = 7'b0010111;
  localparam logic [6:0] OPC_LUI     = 7'b0110111;

  // funct7 values, muldiv only used to reject M encodings
  localparam logic [6:0] F7_BASE   = 7'b0000000;
  localparam logic [6:0] F7_ALT    = 7'b0100000;
  localparam logic [6:0] F7_MULDIV = 7'b0000001;

  // group code field, common to every bus
  localparam int INFOBUS_OP_LSB = 0;
  localparam int INFOBUS_OP_W   = 3;
  localparam logic [INFOBUS_OP_W-1:0] INFOBUS_OP_ALU = 3'd0;
  localparam logic [INFOBUS_OP_W-1:0] INFOBUS_OP_BJP = 3'd1;
  localparam logic [INFOBUS_OP_W-1:0] INFOBUS_OP_LSU = 3'd2;

  // alu bus fields
  localparam int INFOBUS_ALU_RV32  = 3;
  localparam int INFOBUS_ALU_ADD   = 4;
  localparam int INFOBUS_ALU_SUB   = 5;
  localparam int INFOBUS_ALU_SLT   = 6;
  localparam int INFOBUS_ALU_SLTU  = 7;
  localparam int INFOBUS_ALU_XOR   = 8;
  localparam int INFOBUS_ALU_SLL   = 9;
  localparam int INFOBUS_ALU_SRL   = 10;
  localparam int INFOBUS_ALU_SRA   = 11;
  localparam int INFOBUS_ALU_OR    = 12;
  localparam int INFOBUS_ALU_AND   = 13;
  localparam int INFOBUS_ALU_LUI   = 14;
  localparam int INFOBUS_ALU_IMM   = 15;
  localparam int INFOBUS_ALU_PC    = 16;
  localparam int INFOBUS_ALU_NOP   = 17;
  localparam int INFOBUS_ALU_WIDTH = 18;

  // branch/jump bus fields
  localparam int INFOBUS_BJP_RV32  = 3;
  localparam int INFOBUS_BJP_JUMP  = 4;
  localparam int INFOBUS_BJP_BPRDT = 5;
  localparam int INFOBUS_BJP_BEQ   = 6;
  localparam int INFOBUS_BJP_BNE   = 7;
  localparam int INFOBUS_BJP_BLT   = 8;
  localparam int INFOBUS_BJP_BGT   = 9;
  localparam int INFOBUS_BJP_BLTU  = 10;
  localparam int INFOBUS_BJP_BGTU  = 11;
  localparam int INFOBUS_BJP_BXX   = 12;
  localparam int INFOBUS_BJP_WIDTH = 13;

  // load/store bus fields, size is two bits wide starting at its lsb
  localparam int INFOBUS_LSU_RV32   = 3;
  localparam int INFOBUS_LSU_LOAD   = 4;
  localparam int INFOBUS_LSU_STORE  = 5;
  localparam int INFOBUS_LSU_SIZE   = 6;
  localparam int INFOBUS_LSU_SIZE_W = 2;
  localparam int INFOBUS_LSU_USIGN  = 8;
  localparam int INFOBUS_LSU_OP2IMM = 9;
  localparam int INFOBUS_LSU_FENCE  = 10;
  localparam int INFOBUS_LSU_FENCEI = 11;
  localparam int INFOBUS_LSU_WIDTH  = 12;

endpackage

`default_nettype wire

// ==== hw/lieat_idu_opcode_dec.sv ====
`timescale 1ns/1ps
`default_nettype none

module lieat_idu_opcode_dec import lieat_idu_pkg::*; (
  input  logic [XLEN-1:0] inst,
  output logic            id_rv32,
  output logic            is_load,
  output logic            is_store,
  output logic            is_branch,
  output logic            is_jal,
  output logic            is_jalr,
  output logic            is_miscmem,
  output logic            is_op_imm,
  output logic            is_op,
  output logic            is_lui,
  output logic            is_auipc,
  output logic            op_add,
  output logic            op_sub,
  output logic            op_slt,
  output logic            op_sltu,
  output logic            op_xor,
  output logic            op_sll,
  output logic            op_srl,
  output logic            op_sra,
  output logic            op_or,
  output logic            op_and,
  output logic            br_beq,
  output logic            br_bne,
  output logic            br_blt,
  output logic            br_bgt,
  output logic            br_bltu,
  output logic            br_bgtu,
  output logic            is_fence,
  output logic            is_fencei,
  output logic            is_nop,
  output logic            is_muldiv,
  output logic            shift_ilgl
);

  logic [6:0] opcode;
  logic [2:0] f3;
  logic [6:0] f7;
  logic       f7_base;
  logic       f7_alt;
  // immediate shifts take shamt[5] in bit 25, compare only the upper six bits
  logic       f7_base_sh;
  logic       f7_alt_sh;
  logic       slli;
  logic       srli;
  logic       srai;

  assign opcode     = inst[6:0];
  assign f3         = inst[14:12];
  assign f7         = inst[31:25];
  assign f7_base    = (f7 == F7_BASE);
  assign f7_alt     = (f7 == F7_ALT);
  assign f7_base_sh = (f7[6:1] == F7_BASE[6:1]);
  assign f7_alt_sh  = (f7[6:1] == F7_ALT[6:1]);

  // 32-bit encodings end in 11, bits 4:2 of 111 mark longer formats
  assign id_rv32 = (opcode[1:0] == 2'b11) & (opcode[4:2] != 3'b111);

  // major classes
  assign is_load    = (opcode == OPC_LOAD);
  assign is_store   = (opcode == OPC_STORE);
  assign is_branch  = (opcode == OPC_BRANCH);
  assign is_jal     = (opcode == OPC_JAL);
  assign is_jalr    = (opcode == OPC_JALR);
  assign is_miscmem = (opcode == OPC_MISCMEM);
  assign is_op_imm  = (opcode == OPC_OP_IMM);
  assign is_op      = (opcode == OPC_OP);
  assign is_lui     = (opcode == OPC_LUI);
  assign is_auipc   = (opcode == OPC_AUIPC);

  assign slli = is_op_imm & (f3 == 3'b001) & f7_base_sh;
  assign srli = is_op_imm & (f3 == 3'b101) & f7_base_sh;
  assign srai = is_op_imm & (f3 == 3'b101) & f7_alt_sh;

  // register form merged with immediate form
  assign op_add  = (is_op & (f3 == 3'b000) & f7_base) | (is_op_imm & (f3 == 3'b000));
  assign op_sub  = is_op & (f3 == 3'b000) & f7_alt;
  assign op_slt  = (is_op & (f3 == 3'b010) & f7_base) | (is_op_imm & (f3 == 3'b010));
  assign op_sltu = (is_op & (f3 == 3'b011) & f7_base) | (is_op_imm & (f3 == 3'b011));
  assign op_xor  = (is_op & (f3 == 3'b100) & f7_base) | (is_op_imm & (f3 == 3'b100));
  assign op_sll  = (is_op & (f3 == 3'b001) & f7_base) | slli;
  assign op_srl  = (is_op & (f3 == 3'b101) & f7_base) | srli;
  assign op_sra  = (is_op & (f3 == 3'b101) & f7_alt) | srai;
  assign op_or   = (is_op & (f3 == 3'b110) & f7_base) | (is_op_imm & (f3 == 3'b110));
  assign op_and  = (is_op & (f3 == 3'b111) & f7_base) | (is_op_imm & (f3 == 3'b111));

  // funct3 010 and 011 are reserved for branches
  assign br_beq  = is_branch & (f3 == 3'b000);
  assign br_bne  = is_branch & (f3 == 3'b001);
  assign br_blt  = is_branch & (f3 == 3'b100);
  assign br_bgt  = is_branch & (f3 == 3'b101);
  assign br_bltu = is_branch & (f3 == 3'b110);
  assign br_bgtu = is_branch & (f3 == 3'b111);

  assign is_fence  = is_miscmem & (f3 == 3'b000);
  assign is_fencei = is_miscmem & (f3 == 3'b001);

  // canonical nop is addi x0, x0, 0
  assign is_nop     = is_op_imm & (f3 == 3'b000) & (inst[31:15] == '0) & (inst[11:7] == '0);
  assign is_muldiv  = is_op & (f7 == F7_MULDIV);
  // shamt[5] set is not valid on rv32
  assign shift_ilgl = (slli | srli | srai) & inst[25];

endmodule

`default_nettype wire

// ==== hw/lieat_idu_operand_dec.sv ====
`timescale 1ns/1ps
`default_nettype none

module lieat_idu_operand_dec import lieat_idu_pkg::*; (
  input  logic [XLEN-1:0]    inst,
  input  logic               id_rv32,
  input  logic               is_lui,
  input  logic               is_auipc,
  input  logic               is_jal,
  input  logic               is_fence,
  input  logic               is_fencei,
  input  logic               is_branch,
  input  logic               is_store,
  input  logic               is_op,
  output logic [REG_IDX-1:0] rs1,
  output logic [REG_IDX-1:0] rs2,
  output logic [REG_IDX-1:0] rd,
  output logic               rs1en,
  output logic               rs2en,
  output logic               rdwen
);

  // raw register fields, same place in every format
  logic [REG_IDX-1:0] rs1_f;
  logic [REG_IDX-1:0] rs2_f;
  logic [REG_IDX-1:0] rd_f;

  assign rs1_f = inst[19:15];
  assign rs2_f = inst[24:20];
  assign rd_f  = inst[11:7];

  // non rv32 encodings carry no register fields
  assign rs1 = id_rv32 ? rs1_f : '0;
  assign rs2 = id_rv32 ? rs2_f : '0;
  assign rd  = id_rv32 ? rd_f  : '0;

  // x0 reads are never requested
  assign rs1en = id_rv32 & (rs1_f != '0) &
                 ~(is_lui | is_auipc | is_jal | is_fence | is_fencei);
  assign rs2en = id_rv32 & (rs2_f != '0) & (is_branch | is_store | is_op);
  // writes to x0 are dropped here
  assign rdwen = id_rv32 & (rd_f != '0) &
                 ~(is_branch | is_store | is_fence | is_fencei);

endmodule

`default_nettype wire

// ==== hw/lieat_idu_imm_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module lieat_idu_imm_gen import lieat_idu_pkg::*; (
  input  logic [XLEN-1:0] inst,
  input  logic            is_op_imm,
  input  logic            is_jalr,
  input  logic            is_load,
  input  logic            is_lui,
  input  logic            is_auipc,
  input  logic            is_store,
  input  logic            is_branch,
  input  logic            is_jal,
  output logic [XLEN-1:0] imm,
  output logic            need_imm
);

  logic            fmt_i;
  logic            fmt_u;
  logic            fmt_s;
  logic            fmt_b;
  logic            fmt_j;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_j;

  // format select, at most one is set
  assign fmt_i = is_op_imm | is_jalr | is_load;
  assign fmt_u = is_lui | is_auipc;
  assign fmt_s = is_store;
  assign fmt_b = is_branch;
  assign fmt_j = is_jal;

  // inst[31] is the sign bit in every format
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  // and-or mux, zero when no format applies
  assign imm = ({XLEN{fmt_i}} & imm_i) |
               ({XLEN{fmt_u}} & imm_u) |
               ({XLEN{fmt_s}} & imm_s) |
               ({XLEN{fmt_b}} & imm_b) |
               ({XLEN{fmt_j}} & imm_j);

  assign need_imm = fmt_i | fmt_u | fmt_s | fmt_b | fmt_j;

endmodule

`default_nettype wire

// ==== hw/lieat_idu_infobus_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module lieat_idu_infobus_gen import lieat_idu_pkg::*; (
  input  logic            id_rv32,
  input  logic            prdt_taken,
  input  logic [XLEN-1:0] inst,
  input  logic            need_imm,
  input  logic            is_load,
  input  logic            is_store,
  input  logic            is_branch,
  input  logic            is_jal,
  input  logic            is_jalr,
  input  logic            is_miscmem,
  input  logic            is_op_imm,
  input  logic            is_op,
  input  logic            is_lui,
  input  logic            is_auipc,
  input  logic            op_add,
  input  logic            op_sub,
  input  logic            op_slt,
  input  logic            op_sltu,
  input  logic            op_xor,
  input  logic            op_sll,
  input  logic            op_srl,
  input  logic            op_sra,
  input  logic            op_or,
  input  logic            op_and,
  input  logic            br_beq,
  input  logic            br_bne,
  input  logic            br_blt,
  input  logic            br_bgt,
  input  logic            br_bltu,
  input  logic            br_bgtu,
  input  logic            is_nop,
  input  logic            is_fence,
  input  logic            is_fencei,
  input  logic            is_muldiv,
  input  logic            shift_ilgl,
  output logic [XLEN-1:0] infobus,
  output logic            ilgl
);

  logic                         alu_grp;
  logic                         bjp_grp;
  logic                         lsu_grp;
  logic [INFOBUS_ALU_WIDTH-1:0] alu_bus;
  logic [INFOBUS_BJP_WIDTH-1:0] bjp_bus;
  logic [INFOBUS_LSU_WIDTH-1:0] lsu_bus;

  // group membership, m extension falls out of the alu group
  assign alu_grp = ~shift_ilgl & (is_op_imm | (is_op & ~is_muldiv) | is_lui | is_auipc);
  assign bjp_grp = is_jal | is_jalr | is_branch;
  // only fence and fence.i are valid in misc-mem
  assign lsu_grp = is_load | is_store | (is_miscmem & (is_fence | is_fencei));

  // alu bus, auipc is pc plus imm so it rides on add
  assign alu_bus[INFOBUS_OP_LSB +: INFOBUS_OP_W] = INFOBUS_OP_ALU;
  assign alu_bus[INFOBUS_ALU_RV32] = id_rv32;
  assign alu_bus[INFOBUS_ALU_ADD]  = op_add | is_auipc;
  assign alu_bus[INFOBUS_ALU_SUB]  = op_sub;
  assign alu_bus[INFOBUS_ALU_SLT]  = op_slt;
  assign alu_bus[INFOBUS_ALU_SLTU] = op_sltu;
  assign alu_bus[INFOBUS_ALU_XOR]  = op_xor;
  assign alu_bus[INFOBUS_ALU_SLL]  = op_sll;
  assign alu_bus[INFOBUS_ALU_SRL]  = op_srl;
  assign alu_bus[INFOBUS_ALU_SRA]  = op_sra;
  assign alu_bus[INFOBUS_ALU_OR]   = op_or;
  assign alu_bus[INFOBUS_ALU_AND]  = op_and;
  assign alu_bus[INFOBUS_ALU_LUI]  = is_lui;
  assign alu_bus[INFOBUS_ALU_IMM]  = need_imm;
  assign alu_bus[INFOBUS_ALU_PC]   = is_auipc;
  assign alu_bus[INFOBUS_ALU_NOP]  = is_nop;

  // branch/jump bus
  assign bjp_bus[INFOBUS_OP_LSB +: INFOBUS_OP_W] = INFOBUS_OP_BJP;
  assign bjp_bus[INFOBUS_BJP_RV32]  = id_rv32;
  assign bjp_bus[INFOBUS_BJP_JUMP]  = is_jal | is_jalr;
  assign bjp_bus[INFOBUS_BJP_BPRDT] = prdt_taken;
  assign bjp_bus[INFOBUS_BJP_BEQ]   = br_beq;
  assign bjp_bus[INFOBUS_BJP_BNE]   = br_bne;
  assign bjp_bus[INFOBUS_BJP_BLT]   = br_blt;
  assign bjp_bus[INFOBUS_BJP_BGT]   = br_bgt;
  assign bjp_bus[INFOBUS_BJP_BLTU]  = br_bltu;
  assign bjp_bus[INFOBUS_BJP_BGTU]  = br_bgtu;
  assign bjp_bus[INFOBUS_BJP_BXX]   = is_branch;

  // load/store bus, size and sign straight from funct3
  assign lsu_bus[INFOBUS_OP_LSB +: INFOBUS_OP_W] = INFOBUS_OP_LSU;
  assign lsu_bus[INFOBUS_LSU_RV32]   = id_rv32;
  assign lsu_bus[INFOBUS_LSU_LOAD]   = is_load;
  assign lsu_bus[INFOBUS_LSU_STORE]  = is_store;
  assign lsu_bus[INFOBUS_LSU_SIZE +: INFOBUS_LSU_SIZE_W] = inst[13:12];
  assign lsu_bus[INFOBUS_LSU_USIGN]  = inst[14];
  assign lsu_bus[INFOBUS_LSU_OP2IMM] = need_imm;
  assign lsu_bus[INFOBUS_LSU_FENCE]  = is_fence;
  assign lsu_bus[INFOBUS_LSU_FENCEI] = is_fencei;

  // priority pick, alu first
  always_comb begin
    if (alu_grp) begin
      infobus = {{(XLEN-INFOBUS_ALU_WIDTH){1'b0}}, alu_bus};
    end else if (bjp_grp) begin
      infobus = {{(XLEN-INFOBUS_BJP_WIDTH){1'b0}}, bjp_bus};
    end else if (lsu_grp) begin
      infobus = {{(XLEN-INFOBUS_LSU_WIDTH){1'b0}}, lsu_bus};
    end else begin
      infobus = '0;
    end
  end

  // anything without a group, system included, is illegal
  assign ilgl = (inst == '0) | (inst == '1) | shift_ilgl | ~(alu_grp | bjp_grp | lsu_grp);

endmodule

`default_nettype wire

// ==== hw/lieat_idu_id_ex_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module lieat_idu_id_ex_reg import lieat_idu_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               if_valid,
  input  logic               ex_stall,
  input  logic               flush,
  input  logic [REG_IDX-1:0] rs1,
  input  logic [REG_IDX-1:0] rs2,
  input  logic [REG_IDX-1:0] rd,
  input  logic               rs1en,
  input  logic               rs2en,
  input  logic               rdwen,
  input  logic [XLEN-1:0]    imm,
  input  logic [XLEN-1:0]    infobus,
  input  logic               ilgl,
  output logic               id_valid,
  output logic [REG_IDX-1:0] id_rs1,
  output logic [REG_IDX-1:0] id_rs2,
  output logic [REG_IDX-1:0] id_rd,
  output logic               id_rs1en,
  output logic               id_rs2en,
  output logic               id_rdwen,
  output logic [XLEN-1:0]    id_imm,
  output logic [XLEN-1:0]    id_infobus,
  output logic               id_ilgl
);

  // payload moves only when execute takes it and no flush kills it
  logic load;

  assign load = ~ex_stall & ~flush;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      id_valid   <= 1'b0;
      id_rs1     <= '0;
      id_rs2     <= '0;
      id_rd      <= '0;
      id_rs1en   <= 1'b0;
      id_rs2en   <= 1'b0;
      id_rdwen   <= 1'b0;
      id_imm     <= '0;
      id_infobus <= '0;
      id_ilgl    <= 1'b0;
    end else begin
      // flush beats stall for the valid bit
      if (flush) begin
        id_valid <= 1'b0;
      end else if (!ex_stall) begin
        id_valid <= if_valid;
      end
      // a bubble loads an all-zero payload
      if (load) begin
        id_rs1     <= if_valid ? rs1 : '0;
        id_rs2     <= if_valid ? rs2 : '0;
        id_rd      <= if_valid ? rd : '0;
        id_rs1en   <= if_valid & rs1en;
        id_rs2en   <= if_valid & rs2en;
        id_rdwen   <= if_valid & rdwen;
        id_imm     <= if_valid ? imm : '0;
        id_infobus <= if_valid ? infobus : '0;
        id_ilgl    <= if_valid & ilgl;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/lieat_idu.sv ====
`timescale 1ns/1ps
`default_nettype none

module lieat_idu (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        if_valid,
  input  logic [31:0] inst,
  input  logic        prdt_taken,
  input  logic        ex_stall,
  input  logic        flush,
  output logic        id_valid,
  output logic [4:0]  id_rs1,
  output logic [4:0]  id_rs2,
  output logic [4:0]  id_rd,
  output logic        id_rs1en,
  output logic        id_rs2en,
  output logic        id_rdwen,
  output logic [31:0] id_imm,
  output logic [31:0] id_infobus,
  output logic        id_ilgl
);

  // class and operation flags from the opcode decoder
  logic id_rv32;
  logic is_load, is_store, is_branch, is_jal, is_jalr;
  logic is_miscmem, is_op_imm, is_op, is_lui, is_auipc;
  logic op_add, op_sub, op_slt, op_sltu, op_xor;
  logic op_sll, op_srl, op_sra, op_or, op_and;
  logic br_beq, br_bne, br_blt, br_bgt, br_bltu, br_bgtu;
  logic is_fence, is_fencei, is_nop, is_muldiv, shift_ilgl;

  // next-stage values into the stage register
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [4:0]  rd;
  logic        rs1en;
  logic        rs2en;
  logic        rdwen;
  logic [31:0] imm;
  logic        need_imm;
  logic [31:0] infobus;
  logic        ilgl;

  // port names match the wires above, so implicit connection is enough
  lieat_idu_opcode_dec u_opcode_dec (.*);

  lieat_idu_operand_dec u_operand_dec (.*);

  lieat_idu_imm_gen u_imm_gen (.*);

  lieat_idu_infobus_gen u_infobus_gen (.*);

  // one cycle from accept to the id_ outputs
  lieat_idu_id_ex_reg u_id_ex_reg (.*);

endmodule

`default_nettype wire

// ==== test/lieat_idu_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module lieat_idu_sva import lieat_idu_pkg::*; (
  input logic               clk,
  input logic               rst_n,
  input logic               if_valid,
  input logic               ex_stall,
  input logic               flush,
  input logic               id_valid,
  input logic [REG_IDX-1:0] id_rs1,
  input logic [REG_IDX-1:0] id_rs2,
  input logic [REG_IDX-1:0] id_rd,
  input logic               id_rs1en,
  input logic               id_rs2en,
  input logic               id_rdwen,
  input logic [XLEN-1:0]    id_imm,
  input logic [XLEN-1:0]    id_infobus,
  input logic               id_ilgl
);

  // failures seen so far, watched by the testbench
  int fail_count = 0;

  // everything the stage register holds besides valid
  logic [3*REG_IDX+3+2*XLEN:0] payload;

  assign payload = {id_rs1, id_rs2, id_rd, id_rs1en, id_rs2en, id_rdwen,
                    id_imm, id_infobus, id_ilgl};

  // reset edge leaves an empty stage
  a_reset: assert property (@(posedge clk) !rst_n |=> (!id_valid && payload == '0))
    else begin fail_count++; $error("stage not cleared by reset"); end

  // stall freezes the payload, flush or not
  a_stall_payload: assert property (@(posedge clk) rst_n && ex_stall |=> $stable(payload))
    else begin fail_count++; $error("payload moved during stall"); end

  a_stall_valid: assert property (@(posedge clk)
    rst_n && ex_stall && !flush |=> $stable(id_valid))
    else begin fail_count++; $error("valid moved during stall"); end

  // flush kills valid, also while stalled
  a_flush: assert property (@(posedge clk) rst_n && flush |=> !id_valid)
    else begin fail_count++; $error("valid survived a flush"); end

  // bubble at a moving edge zeroes the payload
  a_bubble: assert property (@(posedge clk)
    rst_n && !ex_stall && !flush && !if_valid |=> (payload == '0))
    else begin fail_count++; $error("bubble left a nonzero payload"); end

endmodule

bind lieat_idu lieat_idu_sva u_sva (.*);

`default_nettype wire

// ==== test/lieat_idu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lieat_idu_tb import lieat_idu_pkg::*; ();

  localparam int N_TESTS = 3000;
  localparam int WATCHDOG_NS = (N_TESTS + 20) * 10 * 2;

  logic        clk;
  logic        rst_n;
  logic        if_valid;
  logic [31:0] inst;
  logic        prdt_taken;
  logic        ex_stall;
  logic        flush;
  logic        id_valid;
  logic [4:0]  id_rs1;
  logic [4:0]  id_rs2;
  logic [4:0]  id_rd;
  logic        id_rs1en;
  logic        id_rs2en;
  logic        id_rdwen;
  logic [31:0] id_imm;
  logic [31:0] id_infobus;
  logic        id_ilgl;

  logic [31:0] lfsr_state;

  // reference stage updated on the same edges as the DUT
  logic        armed = 1'b0;
  logic        exp_valid = 1'b0;
  logic [4:0]  exp_rs1 = '0;
  logic [4:0]  exp_rs2 = '0;
  logic [4:0]  exp_rd = '0;
  logic        exp_rs1en = 1'b0;
  logic        exp_rs2en = 1'b0;
  logic        exp_rdwen = 1'b0;
  logic [31:0] exp_imm = '0;
  logic [31:0] exp_infobus = '0;
  logic        exp_ilgl = 1'b0;

  // decoded values of the current inputs
  logic [4:0]  n_rs1;
  logic [4:0]  n_rs2;
  logic [4:0]  n_rd;
  logic        n_rs1en;
  logic        n_rs2en;
  logic        n_rdwen;
  logic [31:0] n_imm;
  logic [31:0] n_infobus;
  logic        n_ilgl;

  lieat_idu uut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abort_run();
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic flag_mismatch(input string field);
    $display("FAILED at %0t: %s differs from the reference model", $time, field);
    abort_run();
  endtask

  // fibonacci lfsr with taps 32 22 2 1
  // one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int k = 0; k < n; k++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      val = {val[30:0], fb};
    end
    return val;
  endfunction

  // alu bus bit for a funct3
  // alt picks sub or sra
  function automatic int alu_bit(input logic [2:0] f3, input logic alt);
    case (f3)
      3'd0:    return alt ? INFOBUS_ALU_SUB : INFOBUS_ALU_ADD;
      3'd1:    return INFOBUS_ALU_SLL;
      3'd2:    return INFOBUS_ALU_SLT;
      3'd3:    return INFOBUS_ALU_SLTU;
      3'd4:    return INFOBUS_ALU_XOR;
      3'd5:    return alt ? INFOBUS_ALU_SRA : INFOBUS_ALU_SRL;
      3'd6:    return INFOBUS_ALU_OR;
      default: return INFOBUS_ALU_AND;
    endcase
  endfunction

  // random instruction of a class
  // upper classes are raw words
  function automatic logic [31:0] make_inst(input logic [3:0] cls);
    logic [31:0] r;
    logic [2:0]  f3;
    logic [1:0]  sz;
    logic [6:0]  top;
    r = take_bits(32);
    f3 = r[14:12];
    sz = (r[13:12] == 2'b11) ? 2'b10 : r[13:12];
    top = r[31:25];
    case (cls)
      4'd0: begin
        top = (r[30] && (f3 == 3'd0 || f3 == 3'd5)) ? F7_ALT : F7_BASE;
        return {top, r[24:7], OPC_OP};
      end
      4'd1: begin
        if (f3 == 3'd1) top = F7_BASE;
        if (f3 == 3'd5) top = r[30] ? F7_ALT : F7_BASE;
        return {top, r[24:7], OPC_OP_IMM};
      end
      4'd2:  return {r[31:7], OPC_LUI};
      4'd3:  return {r[31:7], OPC_AUIPC};
      4'd4:  return {r[31:7], OPC_JAL};
      4'd5:  return {r[31:15], 3'd0, r[11:7], OPC_JALR};
      4'd6: begin
        // 010 and 011 fold onto beq and bne
        if (f3[2:1] == 2'b01) f3[1] = 1'b0;
        return {r[31:15], f3, r[11:7], OPC_BRANCH};
      end
      4'd7:  return {r[31:15], r[14] & (sz != 2'b10), sz, r[11:7], OPC_LOAD};
      4'd8:  return {r[31:15], 1'b0, sz, r[11:7], OPC_STORE};
      4'd9:  return {r[31:15], 2'b00, r[12], r[11:7], OPC_MISCMEM};
      4'd10: return 32'h0000_0013;
      4'd11: begin
        case (take_bits(3))
          0: return 32'h0000_0000;
          1: return 32'hffff_ffff;
          2: return {1'b0, r[30], 4'b0000, 1'b1, r[24:15], r[14], 2'b01, r[11:7], OPC_OP_IMM};
          3: return {F7_MULDIV, r[24:7], OPC_OP};
          4: return {r[31:7], 7'b1110011};
          default: return {r[31:7], r[6:5], 3'b111, 2'b11};
        endcase
      end
      default: return r;
    endcase
  endfunction

  // decode rules applied to one instruction word
  task automatic decode_ref(input logic [31:0] ins, input logic taken,
                            output logic [4:0] r1, output logic [4:0] r2,
                            output logic [4:0] rdx, output logic e1, output logic e2,
                            output logic ew, output logic [31:0] im,
                            output logic [31:0] bus, output logic bad);
    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       rv32;
    logic       fen;
    logic       feni;
    logic       grp;
    logic       shbad;
    logic       sh_form;
    opc = ins[6:0];
    f3 = ins[14:12];
    f7 = ins[31:25];
    rv32 = (opc[1:0] == 2'b11) && (opc[4:2] != 3'b111);
    fen = (opc == OPC_MISCMEM) && (f3 == 3'd0);
    feni = (opc == OPC_MISCMEM) && (f3 == 3'd1);
    r1 = rv32 ? ins[19:15] : 5'd0;
    r2 = rv32 ? ins[24:20] : 5'd0;
    rdx = rv32 ? ins[11:7] : 5'd0;
    e1 = rv32 && (ins[19:15] != 5'd0) && !(opc inside {OPC_LUI, OPC_AUIPC, OPC_JAL})
         && !fen && !feni;
    e2 = rv32 && (ins[24:20] != 5'd0) && (opc inside {OPC_BRANCH, OPC_STORE, OPC_OP});
    ew = rv32 && (ins[11:7] != 5'd0) && !(opc inside {OPC_BRANCH, OPC_STORE})
         && !fen && !feni;
    case (opc)
      OPC_OP_IMM, OPC_JALR, OPC_LOAD: im = {{20{ins[31]}}, ins[31:20]};
      OPC_LUI, OPC_AUIPC: im = {ins[31:12], 12'h000};
      OPC_STORE:  im = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      OPC_BRANCH: im = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      OPC_JAL:    im = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      default:    im = '0;
    endcase
    bus = '0;
    grp = 1'b1;
    shbad = 1'b0;
    // shift immediates need funct7 base or the srai alt value
    sh_form = (f7[6:1] == 6'd0) || (f3 == 3'd5 && f7[6:1] == F7_ALT[6:1]);
    case (opc)
      OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC: begin
        bus[INFOBUS_OP_LSB +: INFOBUS_OP_W] = INFOBUS_OP_ALU;
        bus[INFOBUS_ALU_RV32] = 1'b1;
        bus[INFOBUS_ALU_IMM] = (opc != OPC_OP);
        if (opc == OPC_OP) begin
          if (f7 == F7_BASE) bus[alu_bit(f3, 1'b0)] = 1'b1;
          else if (f7 == F7_ALT && (f3 == 3'd0 || f3 == 3'd5)) bus[alu_bit(f3, 1'b1)] = 1'b1;
          else if (f7 == F7_MULDIV) grp = 1'b0;
        end else if (opc == OPC_OP_IMM) begin
          if (f3 == 3'd1 || f3 == 3'd5) begin
            if (sh_form && ins[25]) shbad = 1'b1;
            else if (sh_form) bus[alu_bit(f3, f7[5])] = 1'b1;
          end else begin
            bus[alu_bit(f3, 1'b0)] = 1'b1;
          end
          bus[INFOBUS_ALU_NOP] = (f3 == 3'd0) && (ins[31:15] == '0) && (ins[11:7] == '0);
        end else if (opc == OPC_LUI) begin
          bus[INFOBUS_ALU_LUI] = 1'b1;
        end else begin
          bus[INFOBUS_ALU_ADD] = 1'b1;
          bus[INFOBUS_ALU_PC] = 1'b1;
        end
      end
      OPC_JAL, OPC_JALR, OPC_BRANCH: begin
        bus[INFOBUS_OP_LSB +: INFOBUS_OP_W] = INFOBUS_OP_BJP;
        bus[INFOBUS_BJP_RV32] = 1'b1;
        bus[INFOBUS_BJP_JUMP] = (opc != OPC_BRANCH);
        bus[INFOBUS_BJP_BPRDT] = taken;
        bus[INFOBUS_BJP_BXX] = (opc == OPC_BRANCH);
        if (opc == OPC_BRANCH) begin
          case (f3)
            3'd0: bus[INFOBUS_BJP_BEQ] = 1'b1;
            3'd1: bus[INFOBUS_BJP_BNE] = 1'b1;
            3'd4: bus[INFOBUS_BJP_BLT] = 1'b1;
            3'd5: bus[INFOBUS_BJP_BGT] = 1'b1;
            3'd6: bus[INFOBUS_BJP_BLTU] = 1'b1;
            3'd7: bus[INFOBUS_BJP_BGTU] = 1'b1;
            default: bus[INFOBUS_BJP_BXX] = 1'b1;
          endcase
        end
      end
      OPC_LOAD, OPC_STORE, OPC_MISCMEM: begin
        bus[INFOBUS_OP_LSB +: INFOBUS_OP_W] = INFOBUS_OP_LSU;
        bus[INFOBUS_LSU_RV32] = 1'b1;
        bus[INFOBUS_LSU_LOAD] = (opc == OPC_LOAD);
        bus[INFOBUS_LSU_STORE] = (opc == OPC_STORE);
        bus[INFOBUS_LSU_SIZE +: INFOBUS_LSU_SIZE_W] = f3[1:0];
        bus[INFOBUS_LSU_USIGN] = f3[2];
        bus[INFOBUS_LSU_OP2IMM] = (opc != OPC_MISCMEM);
        bus[INFOBUS_LSU_FENCE] = fen;
        bus[INFOBUS_LSU_FENCEI] = feni;
        if (opc == OPC_MISCMEM && !fen && !feni) grp = 1'b0;
      end
      default: grp = 1'b0;
    endcase
    // bad shifts leave the alu group too
    if (shbad) grp = 1'b0;
    if (!grp) bus = '0;
    bad = (ins == '0) || (ins == '1) || !grp;
  endtask

  // stage register model where flush beats stall
  // bubbles zero the payload
  always @(posedge clk) begin
    decode_ref(inst, prdt_taken, n_rs1, n_rs2, n_rd, n_rs1en, n_rs2en, n_rdwen,
               n_imm, n_infobus, n_ilgl);
    armed <= 1'b1;
    if (!rst_n) begin
      exp_valid <= 1'b0;
      {exp_rs1, exp_rs2, exp_rd, exp_rs1en, exp_rs2en, exp_rdwen} <= '0;
      {exp_imm, exp_infobus, exp_ilgl} <= '0;
    end else begin
      if (flush) exp_valid <= 1'b0;
      else if (!ex_stall) exp_valid <= if_valid;
      if (!ex_stall && !flush) begin
        if (if_valid) begin
          {exp_rs1, exp_rs2, exp_rd} <= {n_rs1, n_rs2, n_rd};
          {exp_rs1en, exp_rs2en, exp_rdwen} <= {n_rs1en, n_rs2en, n_rdwen};
          {exp_imm, exp_infobus, exp_ilgl} <= {n_imm, n_infobus, n_ilgl};
        end else begin
          {exp_rs1, exp_rs2, exp_rd, exp_rs1en, exp_rs2en, exp_rdwen} <= '0;
          {exp_imm, exp_infobus, exp_ilgl} <= '0;
        end
      end
    end
  end

  // compared mid cycle away from both edges
  a_valid: assert property (@(negedge clk) disable iff (!armed) id_valid == exp_valid)
    else flag_mismatch("id_valid");
  a_rs1: assert property (@(negedge clk) disable iff (!armed) id_rs1 == exp_rs1)
    else flag_mismatch("id_rs1");
  a_rs2: assert property (@(negedge clk) disable iff (!armed) id_rs2 == exp_rs2)
    else flag_mismatch("id_rs2");
  a_rd: assert property (@(negedge clk) disable iff (!armed) id_rd == exp_rd)
    else flag_mismatch("id_rd");
  a_rs1en: assert property (@(negedge clk) disable iff (!armed) id_rs1en == exp_rs1en)
    else flag_mismatch("id_rs1en");
  a_rs2en: assert property (@(negedge clk) disable iff (!armed) id_rs2en == exp_rs2en)
    else flag_mismatch("id_rs2en");
  a_rdwen: assert property (@(negedge clk) disable iff (!armed) id_rdwen == exp_rdwen)
    else flag_mismatch("id_rdwen");
  a_imm: assert property (@(negedge clk) disable iff (!armed) id_imm == exp_imm)
    else flag_mismatch("id_imm");
  a_infobus: assert property (@(negedge clk) disable iff (!armed) id_infobus == exp_infobus)
    else flag_mismatch("id_infobus");
  a_ilgl: assert property (@(negedge clk) disable iff (!armed) id_ilgl == exp_ilgl)
    else flag_mismatch("id_ilgl");
  // bound checks on the stage register count their failures
  a_bound: assert property (@(negedge clk) uut.u_sva.fail_count == 0)
    else flag_mismatch("bound stage register check");

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the stimulus finished");
    abort_run();
  end

  initial begin
    logic stall_now;
    rst_n = 1'b0;
    if_valid = 1'b0;
    inst = '0;
    prdt_taken = 1'b0;
    ex_stall = 1'b0;
    flush = 1'b0;
    lfsr_state = 32'h3ac397d8;
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;
    for (int i = 0; i < N_TESTS; i++) begin
      // fetch holds its word while execute stalls
      stall_now = (take_bits(3) == 0);
      ex_stall = stall_now;
      flush = (take_bits(4) == 0);
      if (!stall_now) begin
        if_valid = (take_bits(3) != 0);
        inst = make_inst(4'(take_bits(4)));
        prdt_taken = (take_bits(1) != 0);
      end
      @(posedge clk);
      #1;
    end
    ex_stall = 1'b0;
    flush = 1'b0;
    if_valid = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    #1;
    if (uut.u_sva.fail_count != 0) begin
      $display("bound stage register checks reported errors");
      abort_run();
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== all.f ====
hw/lieat_idu_pkg.sv
hw/lieat_idu_opcode_dec.sv
hw/lieat_idu_operand_dec.sv
hw/lieat_idu_imm_gen.sv
hw/lieat_idu_infobus_gen.sv
hw/lieat_idu_id_ex_reg.sv
hw/lieat_idu.sv
test/lieat_idu_sva.sv
test/lieat_idu_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module lieat_idu_tb -Mdir obj_dir -f all.f

out=$(./obj_dir/Vlieat_idu_tb 2>&1 || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Regression passed"; then
  exit 0
fi
exit 1
